//--- common/dma_consts.svh
`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

// Stream and memory word width in bits
`define DMA_DATA_WIDTH 64

// Bytes per word, one strobe or tkeep bit each
`define DMA_STRB_WIDTH 8

// Bits needed to index a byte lane inside one word
`define DMA_MASK_BITS 3

// Byte address width on the memory side
`define DMA_ADDR_WIDTH 16

// Receive descriptor fields
`define DMA_LEN_WIDTH 16
`define DMA_DEST_WIDTH 8
`define DMA_USER_WIDTH 2

`endif

//--- common/dma_pkg.sv
`include "dma_consts.svh"

package dma_pkg;

  // Word index over byte lane, the split view of a byte address
  typedef struct packed {
    logic [`DMA_ADDR_WIDTH-`DMA_MASK_BITS-1:0] word_idx;
    logic [`DMA_MASK_BITS-1:0]                 lane;
  } word_lane_t;

  // The same address bits read either raw or as word and lane
  typedef union packed {
    logic [`DMA_ADDR_WIDTH-1:0] raw;
    word_lane_t                 w;
  } byte_addr_u;

  // Bytes from the base lane up to the word end, 1 to 8
  typedef logic [`DMA_MASK_BITS:0] lane_off_t;

  // Number of set bits in one strobe word, 0 to 8
  typedef logic [`DMA_MASK_BITS:0] byte_cnt_t;

endpackage

//--- rx_path/rx_ingress_ctrl.sv
`timescale 1ns/10ps
`include "dma_consts.svh"

module rx_ingress_ctrl (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       s_axis_tvalid,
  input  logic                       s_axis_tlast,
  input  logic [`DMA_DEST_WIDTH-1:0] s_axis_tdest,
  input  logic [`DMA_USER_WIDTH-1:0] s_axis_tuser,
  input  dma_pkg::byte_addr_u        wr_base_addr,
  input  logic                       mem_wr_ready,
  input  logic                       wr_en,
  input  logic                       wr_last,
  input  logic                       extra_beat,
  input  logic                       desc_block,
  output logic                       s_axis_tready,
  output logic                       beat_accept,
  output logic                       first_beat,
  output dma_pkg::lane_off_t         wr_offset,
  output logic [`DMA_ADDR_WIDTH-1:0] mem_wr_addr,
  output dma_pkg::byte_addr_u        start_addr,
  output logic [`DMA_DEST_WIDTH-1:0] pkt_tdest,
  output logic [`DMA_USER_WIDTH-1:0] pkt_tuser
);

  localparam logic st_idle = 1'b0;
  localparam logic st_busy = 1'b1;

  logic                state;
  logic                latch_info;
  logic                last_done;
  dma_pkg::byte_addr_u cur_addr;
  dma_pkg::byte_addr_u next_addr;

  ////////////////////////////////////////////////////////////////////////////
  // Stream handshake and packet state
  ////////////////////////////////////////////////////////////////////////////

  // No beat enters during the drain write, and a tlast beat waits
  // until the previous descriptor has been taken
  assign s_axis_tready = mem_wr_ready && !extra_beat && !(s_axis_tlast && desc_block);
  assign beat_accept   = s_axis_tvalid && s_axis_tready;
  assign last_done     = wr_last && mem_wr_ready;

  // A new packet starts from idle or right behind the last write of the
  // previous one
  assign latch_info = ((state == st_idle) || last_done) && beat_accept;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else if ((state == st_idle) && beat_accept) begin
      state <= st_busy;
    end else if ((state == st_busy) && last_done && !beat_accept) begin
      state <= st_idle;
    end
  end

  // Per-packet metadata, sampled with the first accepted beat
  always_ff @(posedge clk) begin
    if (latch_info) begin
      start_addr <= wr_base_addr;
      wr_offset  <= dma_pkg::lane_off_t'(`DMA_STRB_WIDTH) - {1'b0, wr_base_addr.w.lane};
      pkt_tdest  <= s_axis_tdest;
      pkt_tuser  <= s_axis_tuser;
    end
  end

  // Follows the first beat into stage one and stays set until the first
  // write of the packet is accepted
  always_ff @(posedge clk) begin
    if (rst) begin
      first_beat <= 1'b0;
    end else begin
      first_beat <= latch_info || (first_beat && !mem_wr_ready);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Word aligned write address
  ////////////////////////////////////////////////////////////////////////////

  // The first write goes to the word holding the base address
  always_comb begin
    cur_addr = next_addr;
    if (first_beat) begin
      cur_addr.w.word_idx = start_addr.w.word_idx;
      cur_addr.w.lane     = '0;
    end
  end

  // Each accepted write moves on by one word
  always_ff @(posedge clk) begin
    if (wr_en && mem_wr_ready) begin
      next_addr.w.word_idx <= cur_addr.w.word_idx + 1'b1;
      next_addr.w.lane     <= '0;
    end
  end

  assign mem_wr_addr = cur_addr.raw;

  // The memory side relies on the address staying put during a stall
  addr_hold_a : assert property (@(posedge clk) disable iff (rst)
    wr_en && !mem_wr_ready |=> $stable(mem_wr_addr))
    else $error("write address changed while the memory port stalled");

endmodule

//--- rx_path/rx_align_pipe.sv
`timescale 1ns/10ps
`include "dma_consts.svh"

module rx_align_pipe (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`DMA_DATA_WIDTH-1:0] s_axis_tdata,
  input  logic [`DMA_STRB_WIDTH-1:0] s_axis_tkeep,
  input  logic                       s_axis_tlast,
  input  logic                       beat_accept,
  input  logic                       first_beat,
  input  dma_pkg::lane_off_t         wr_offset,
  input  logic                       mem_wr_ready,
  output logic [`DMA_DATA_WIDTH-1:0] mem_wr_data,
  output logic [`DMA_STRB_WIDTH-1:0] mem_wr_strb,
  output logic                       wr_en,
  output logic                       wr_last,
  output logic                       extra_beat
);

  logic [`DMA_DATA_WIDTH-1:0]   data_1;
  logic [`DMA_DATA_WIDTH-1:0]   data_2;
  logic [`DMA_STRB_WIDTH-1:0]   strb_1;
  logic [`DMA_STRB_WIDTH-1:0]   strb_2;
  logic [`DMA_STRB_WIDTH-1:0]   strb_low;
  logic                         last_1;
  logic                         drain_q;
  logic                         advance;
  logic                         tail_left;
  logic [2*`DMA_DATA_WIDTH-1:0] data_cat;
  logic [2*`DMA_STRB_WIDTH-1:0] strb_cat;

  // The pipe moves only when the current write is taken
  assign advance = wr_en && mem_wr_ready;

  // Stage one bytes that do not fit below the word end after the shift
  assign tail_left  = |(strb_1 >> wr_offset);
  assign extra_beat = last_1 && tail_left;

  // The last write is either the last beat itself or the drain behind it
  assign wr_last = wr_en && ((last_1 && !extra_beat) || drain_q);

  ////////////////////////////////////////////////////////////////////////////
  // Stage one holds the newest stream beat
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      strb_1 <= '0;
      last_1 <= 1'b0;
    end else if (extra_beat && advance) begin
      // Its bytes now live only in stage two, so the drain write sees
      // nothing new from stage one
      strb_1 <= '0;
      last_1 <= 1'b0;
    end else if (beat_accept) begin
      strb_1 <= s_axis_tkeep;
      last_1 <= s_axis_tlast;
    end
  end

  always_ff @(posedge clk) begin
    if (beat_accept) begin
      data_1 <= s_axis_tdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage two holds the previous beat of the same packet
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (advance) begin
      data_2 <= data_1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      strb_2  <= '0;
      drain_q <= 1'b0;
    end else begin
      // Empty after the last write so the next packet starts clean
      if (wr_last && mem_wr_ready) begin
        strb_2 <= '0;
      end else if (advance) begin
        strb_2 <= strb_1;
      end
      if (advance) begin
        drain_q <= extra_beat;
      end
    end
  end

  // A write is pending after each accepted beat, for the drain beat, and
  // for as long as memory holds the current one off
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= beat_accept || (advance && extra_beat) || (wr_en && !mem_wr_ready);
    end
  end

  // Nothing below the base lane is written in the first word
  assign strb_low = first_beat ? '0 : strb_2;

  // Both stages side by side, shifted down by the lane offset
  assign data_cat    = {data_1, data_2} >> {wr_offset, 3'b000};
  assign strb_cat    = {strb_1, strb_low} >> wr_offset;
  assign mem_wr_data = data_cat[`DMA_DATA_WIDTH-1:0];
  assign mem_wr_strb = strb_cat[`DMA_STRB_WIDTH-1:0];

  // The last mark rides on a valid write and stays until it is taken
  last_hold_a : assert property (@(posedge clk) disable iff (rst)
    wr_last && !mem_wr_ready |=> wr_last)
    else $error("last write mark dropped before acceptance");

endmodule

//--- rx_path/recv_desc_gen.sv
`timescale 1ns/10ps
`include "dma_consts.svh"

module recv_desc_gen (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`DMA_STRB_WIDTH-1:0] mem_wr_strb,
  input  logic                       wr_en,
  input  logic                       wr_last,
  input  logic                       mem_wr_ready,
  input  logic                       first_beat,
  input  dma_pkg::byte_addr_u        start_addr,
  input  logic [`DMA_DEST_WIDTH-1:0] pkt_tdest,
  input  logic [`DMA_USER_WIDTH-1:0] pkt_tuser,
  input  logic                       recv_desc_ready,
  output logic                       recv_desc_valid,
  output logic [`DMA_ADDR_WIDTH-1:0] recv_desc_addr,
  output logic [`DMA_LEN_WIDTH-1:0]  recv_desc_len,
  output logic [`DMA_DEST_WIDTH-1:0] recv_desc_tdest,
  output logic [`DMA_USER_WIDTH-1:0] recv_desc_tuser,
  output logic                       desc_block
);

  dma_pkg::byte_cnt_t         byte_cnt;
  logic [`DMA_LEN_WIDTH-1:0]  cnt_ext;
  logic [`DMA_LEN_WIDTH-1:0]  pkt_len;
  logic [`DMA_LEN_WIDTH-1:0]  next_len;
  logic                       last_done;
  logic                       load_now;
  logic                       load_late;
  logic                       late_pend;
  dma_pkg::byte_addr_u        desc_addr;
  dma_pkg::byte_addr_u        pend_addr;
  logic [`DMA_LEN_WIDTH-1:0]  pend_len;
  logic [`DMA_DEST_WIDTH-1:0] pend_tdest;
  logic [`DMA_USER_WIDTH-1:0] pend_tuser;

  // Bytes carried by the current write, sparse strobes included
  always_comb begin
    byte_cnt = '0;
    for (int i = 0; i < `DMA_STRB_WIDTH; i++) begin
      byte_cnt = byte_cnt + dma_pkg::byte_cnt_t'(mem_wr_strb[i]);
    end
  end

  assign cnt_ext  = {{(`DMA_LEN_WIDTH - $bits(byte_cnt)){1'b0}}, byte_cnt};
  // The first write of a packet restarts the running length
  assign next_len = first_beat ? cnt_ext : pkt_len + cnt_ext;

  always_ff @(posedge clk) begin
    if (wr_en && mem_wr_ready) begin
      pkt_len <= next_len;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Descriptor issue and the late path behind a blocked one
  ////////////////////////////////////////////////////////////////////////////

  assign desc_block = recv_desc_valid && !recv_desc_ready;
  assign last_done  = wr_last && mem_wr_ready;
  assign load_now   = last_done && !desc_block;
  assign load_late  = late_pend && recv_desc_ready;

  // Remember a finished packet whose descriptor could not be loaded yet
  always_ff @(posedge clk) begin
    if (rst) begin
      late_pend <= 1'b0;
    end else if (last_done && desc_block) begin
      late_pend <= 1'b1;
    end else if (recv_desc_ready) begin
      late_pend <= 1'b0;
    end
  end

  // The next packet may latch new metadata before the late load happens
  always_ff @(posedge clk) begin
    if (last_done && desc_block) begin
      pend_addr  <= start_addr;
      pend_len   <= next_len;
      pend_tdest <= pkt_tdest;
      pend_tuser <= pkt_tuser;
    end
  end

  always_ff @(posedge clk) begin
    if (load_now) begin
      desc_addr       <= start_addr;
      recv_desc_len   <= next_len;
      recv_desc_tdest <= pkt_tdest;
      recv_desc_tuser <= pkt_tuser;
    end else if (load_late) begin
      desc_addr       <= pend_addr;
      recv_desc_len   <= pend_len;
      recv_desc_tdest <= pend_tdest;
      recv_desc_tuser <= pend_tuser;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      recv_desc_valid <= 1'b0;
    end else if (load_now || load_late) begin
      recv_desc_valid <= 1'b1;
    end else if (recv_desc_ready) begin
      recv_desc_valid <= 1'b0;
    end
  end

  assign recv_desc_addr = desc_addr.raw;

  // A held descriptor keeps every field until the consumer takes it
  desc_hold_a : assert property (@(posedge clk) disable iff (rst)
    recv_desc_valid && !recv_desc_ready |=> recv_desc_valid &&
      $stable({recv_desc_addr, recv_desc_len, recv_desc_tdest, recv_desc_tuser}))
    else $error("receive descriptor changed while blocked");

endmodule

//--- hw/axis_dma_rx.sv
`timescale 1ns/10ps
`include "dma_consts.svh"

module axis_dma_rx (
  input  logic                       clk,
  input  logic                       rst,

  input  logic [`DMA_DATA_WIDTH-1:0] s_axis_tdata,
  input  logic [`DMA_STRB_WIDTH-1:0] s_axis_tkeep,
  input  logic                       s_axis_tvalid,
  output logic                       s_axis_tready,
  input  logic                       s_axis_tlast,
  input  logic [`DMA_DEST_WIDTH-1:0] s_axis_tdest,
  input  logic [`DMA_USER_WIDTH-1:0] s_axis_tuser,

  input  logic [`DMA_ADDR_WIDTH-1:0] wr_base_addr,

  output logic                       mem_wr_en,
  input  logic                       mem_wr_ready,
  output logic [`DMA_ADDR_WIDTH-1:0] mem_wr_addr,
  output logic [`DMA_DATA_WIDTH-1:0] mem_wr_data,
  output logic [`DMA_STRB_WIDTH-1:0] mem_wr_strb,
  output logic                       mem_wr_last,

  output logic                       recv_desc_valid,
  input  logic                       recv_desc_ready,
  output logic [`DMA_ADDR_WIDTH-1:0] recv_desc_addr,
  output logic [`DMA_LEN_WIDTH-1:0]  recv_desc_len,
  output logic [`DMA_DEST_WIDTH-1:0] recv_desc_tdest,
  output logic [`DMA_USER_WIDTH-1:0] recv_desc_tuser
);

  ////////////////////////////////////////////////////////////////////////////
  // Links between the ingress control, the align pipe and the descriptor
  ////////////////////////////////////////////////////////////////////////////

  // Accepted stream beat and the flag that marks a packet's first write
  logic                       beat_accept;
  logic                       first_beat;
  // Shift used to realign the packet onto its base lane
  dma_pkg::lane_off_t         wr_offset;
  // High while the last beat still has bytes past the word end
  logic                       extra_beat;
  // Metadata latched with the first beat of the packet
  dma_pkg::byte_addr_u        start_addr;
  logic [`DMA_DEST_WIDTH-1:0] pkt_tdest;
  logic [`DMA_USER_WIDTH-1:0] pkt_tuser;
  // A descriptor is waiting and the consumer is not taking it
  logic                       desc_block;

  rx_ingress_ctrl ingress_i (
    .clk           (clk),
    .rst           (rst),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tlast  (s_axis_tlast),
    .s_axis_tdest  (s_axis_tdest),
    .s_axis_tuser  (s_axis_tuser),
    .wr_base_addr  (wr_base_addr),
    .mem_wr_ready  (mem_wr_ready),
    .wr_en         (mem_wr_en),
    .wr_last       (mem_wr_last),
    .extra_beat    (extra_beat),
    .desc_block    (desc_block),
    .s_axis_tready (s_axis_tready),
    .beat_accept   (beat_accept),
    .first_beat    (first_beat),
    .wr_offset     (wr_offset),
    .mem_wr_addr   (mem_wr_addr),
    .start_addr    (start_addr),
    .pkt_tdest     (pkt_tdest),
    .pkt_tuser     (pkt_tuser)
  );

  rx_align_pipe align_i (
    .clk          (clk),
    .rst          (rst),
    .s_axis_tdata (s_axis_tdata),
    .s_axis_tkeep (s_axis_tkeep),
    .s_axis_tlast (s_axis_tlast),
    .beat_accept  (beat_accept),
    .first_beat   (first_beat),
    .wr_offset    (wr_offset),
    .mem_wr_ready (mem_wr_ready),
    .mem_wr_data  (mem_wr_data),
    .mem_wr_strb  (mem_wr_strb),
    .wr_en        (mem_wr_en),
    .wr_last      (mem_wr_last),
    .extra_beat   (extra_beat)
  );

  recv_desc_gen desc_i (
    .clk             (clk),
    .rst             (rst),
    .mem_wr_strb     (mem_wr_strb),
    .wr_en           (mem_wr_en),
    .wr_last         (mem_wr_last),
    .mem_wr_ready    (mem_wr_ready),
    .first_beat      (first_beat),
    .start_addr      (start_addr),
    .pkt_tdest       (pkt_tdest),
    .pkt_tuser       (pkt_tuser),
    .recv_desc_ready (recv_desc_ready),
    .recv_desc_valid (recv_desc_valid),
    .recv_desc_addr  (recv_desc_addr),
    .recv_desc_len   (recv_desc_len),
    .recv_desc_tdest (recv_desc_tdest),
    .recv_desc_tuser (recv_desc_tuser),
    .desc_block      (desc_block)
  );

endmodule

//--- tb/tb_axis_dma_rx.sv
`timescale 1ns/10ps
`include "dma_consts.svh"

module tb_axis_dma_rx;

  logic                       clk;
  logic                       rst;
  logic [`DMA_DATA_WIDTH-1:0] s_axis_tdata;
  logic [`DMA_STRB_WIDTH-1:0] s_axis_tkeep;
  logic                       s_axis_tvalid;
  logic                       s_axis_tready;
  logic                       s_axis_tlast;
  logic [`DMA_DEST_WIDTH-1:0] s_axis_tdest;
  logic [`DMA_USER_WIDTH-1:0] s_axis_tuser;
  logic [`DMA_ADDR_WIDTH-1:0] wr_base_addr;
  logic                       mem_wr_en;
  logic                       mem_wr_ready;
  logic [`DMA_ADDR_WIDTH-1:0] mem_wr_addr;
  logic [`DMA_DATA_WIDTH-1:0] mem_wr_data;
  logic [`DMA_STRB_WIDTH-1:0] mem_wr_strb;
  logic                       mem_wr_last;
  logic                       recv_desc_valid;
  logic                       recv_desc_ready;
  logic [`DMA_ADDR_WIDTH-1:0] recv_desc_addr;
  logic [`DMA_LEN_WIDTH-1:0]  recv_desc_len;
  logic [`DMA_DEST_WIDTH-1:0] recv_desc_tdest;
  logic [`DMA_USER_WIDTH-1:0] recv_desc_tuser;

  integer seed;
  int     errors;
  int     errs_at_start;
  int     tests_run;
  int     tests_bad;
  // Stimulus phase flags read by the ready driver
  logic   started;
  logic   mem_rand;
  int     desc_mode;
  logic [`DMA_ADDR_WIDTH-1:0] next_base;

  // Memory model, one entry per byte address
  logic [7:0] mem [0:(1<<`DMA_ADDR_WIDTH)-1];
  // Packets still being written, in stream order
  logic [`DMA_ADDR_WIDTH-1:0] pb_q[$];
  int                         pl_q[$];
  logic [7:0]                 eb_q[$];
  int                         wr_cnt;
  int                         wr_bytes;
  // Descriptors still expected, in packet order
  logic [`DMA_ADDR_WIDTH-1:0] da_q[$];
  int                         dl_q[$];
  logic [`DMA_DEST_WIDTH-1:0] dd_q[$];
  logic [`DMA_USER_WIDTH-1:0] du_q[$];
  // Write data with the unstrobed bytes zeroed
  logic [`DMA_DATA_WIDTH-1:0] kept_data;

  axis_dma_rx dut_i (
    .clk             (clk),
    .rst             (rst),
    .s_axis_tdata    (s_axis_tdata),
    .s_axis_tkeep    (s_axis_tkeep),
    .s_axis_tvalid   (s_axis_tvalid),
    .s_axis_tready   (s_axis_tready),
    .s_axis_tlast    (s_axis_tlast),
    .s_axis_tdest    (s_axis_tdest),
    .s_axis_tuser    (s_axis_tuser),
    .wr_base_addr    (wr_base_addr),
    .mem_wr_en       (mem_wr_en),
    .mem_wr_ready    (mem_wr_ready),
    .mem_wr_addr     (mem_wr_addr),
    .mem_wr_data     (mem_wr_data),
    .mem_wr_strb     (mem_wr_strb),
    .mem_wr_last     (mem_wr_last),
    .recv_desc_valid (recv_desc_valid),
    .recv_desc_ready (recv_desc_ready),
    .recv_desc_addr  (recv_desc_addr),
    .recv_desc_len   (recv_desc_len),
    .recv_desc_tdest (recv_desc_tdest),
    .recv_desc_tuser (recv_desc_tuser)
  );

  always #4 clk = ~clk;

  always_comb begin
    for (int i = 0; i < `DMA_STRB_WIDTH; i++) begin
      kept_data[8*i +: 8] = mem_wr_strb[i] ? mem_wr_data[8*i +: 8] : 8'h00;
    end
  end

  task automatic note_error(input string msg);
    errors++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  task automatic abort_run(input string what);
    $display("timeout: gave up waiting for %s", what);
    $display("tests failed");
    $finish;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Protocol checks on every clock edge
  ////////////////////////////////////////////////////////////////////////////

  // Everything stays quiet between reset and the first stimulus
  quiet_a : assert property (@(posedge clk) disable iff (rst)
    !started |-> !s_axis_tready && !mem_wr_en && !mem_wr_last && !recv_desc_valid)
    else note_error("port active before stimulus began");

  // A stalled write keeps all of its fields
  wr_hold_a : assert property (@(posedge clk) disable iff (rst)
    mem_wr_en && !mem_wr_ready |=> mem_wr_en && $stable(mem_wr_addr) &&
      $stable(mem_wr_strb) && $stable(mem_wr_last) && $stable(kept_data))
    else note_error("write fields changed while mem_wr_ready was low");

  last_en_a : assert property (@(posedge clk) disable iff (rst)
    mem_wr_last |-> mem_wr_en)
    else note_error("mem_wr_last without mem_wr_en");

  // The packet end must wait for a pending descriptor to be taken
  tlast_a : assert property (@(posedge clk) disable iff (rst)
    recv_desc_valid && !recv_desc_ready && s_axis_tlast |-> !(s_axis_tvalid && s_axis_tready))
    else note_error("tlast beat accepted while a descriptor was pending");

  desc_hold_a : assert property (@(posedge clk) disable iff (rst)
    recv_desc_valid && !recv_desc_ready |=> recv_desc_valid &&
      $stable({recv_desc_addr, recv_desc_len, recv_desc_tdest, recv_desc_tuser}))
    else note_error("descriptor changed while recv_desc_ready was low");

  ////////////////////////////////////////////////////////////////////////////
  // Memory model and descriptor scoreboard
  ////////////////////////////////////////////////////////////////////////////

  task automatic apply_write();
    int         a;
    int         base;
    int         len;
    logic [7:0] e;
    if (pb_q.size() == 0) begin
      note_error("memory write with no packet outstanding");
      return;
    end
    base = pb_q[0];
    len  = pl_q[0];
    for (int i = 0; i < `DMA_STRB_WIDTH; i++) begin
      if (mem_wr_strb[i]) begin
        a = mem_wr_addr + i;
        range_a : assert (a >= base && a < base + len)
          else note_error($sformatf("strobe at %h outside packet at %h", a, base));
        mem[a] = mem_wr_data[8*i +: 8];
        wr_bytes++;
      end
    end
    wr_cnt++;
    if (mem_wr_last) begin
      // One write per memory word the packet touches, drain included
      words_a : assert (wr_cnt == ((base % 8) + len + 7) / 8)
        else note_error($sformatf("packet at %h took %0d writes", base, wr_cnt));
      count_a : assert (wr_bytes == len)
        else note_error($sformatf("packet at %h wrote %0d bytes", base, wr_bytes));
      for (int i = 0; i < len; i++) begin
        e = eb_q.pop_front();
        byte_a : assert (mem[base + i] === e)
          else note_error($sformatf("byte %h is %h, expected %h", base + i, mem[base + i], e));
      end
      void'(pb_q.pop_front());
      void'(pl_q.pop_front());
      wr_cnt   = 0;
      wr_bytes = 0;
    end
  endtask

  task automatic check_desc();
    if (da_q.size() == 0) begin
      note_error("descriptor with no packet outstanding");
      return;
    end
    desc_a : assert (recv_desc_addr == da_q[0] && recv_desc_len == dl_q[0] &&
                     recv_desc_tdest == dd_q[0] && recv_desc_tuser == du_q[0])
      else note_error($sformatf("descriptor %h/%0d/%h/%h, expected %h/%0d/%h/%h",
        recv_desc_addr, recv_desc_len, recv_desc_tdest, recv_desc_tuser,
        da_q[0], dl_q[0], dd_q[0], du_q[0]));
    void'(da_q.pop_front());
    void'(dl_q.pop_front());
    void'(dd_q.pop_front());
    void'(du_q.pop_front());
  endtask

  // Handshakes are stable mid cycle and transfer on the next rising edge
  always @(negedge clk) begin
    if (!rst && mem_wr_en && mem_wr_ready) begin
      apply_write();
    end
    if (!rst && recv_desc_valid && recv_desc_ready) begin
      check_desc();
    end
  end

  // Ready driver for the memory port and the descriptor port
  always @(posedge clk) begin
    #1;
    if (started) begin
      mem_wr_ready = mem_rand ? (($random(seed) & 3) != 0) : 1'b1;
      case (desc_mode)
        0:       recv_desc_ready = 1'b1;
        1:       recv_desc_ready = 1'b0;
        default: recv_desc_ready = (($random(seed) & 3) == 0);
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stream stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic wait_accept();
    int t;
    t = 0;
    @(negedge clk);
    while (!s_axis_tready) begin
      t++;
      if (t > 500) abort_run("a stream beat to be accepted");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic send_packet(input int nbytes, input logic [2:0] lane);
    int                         nbeats;
    logic [`DMA_ADDR_WIDTH-1:0] base;
    logic [`DMA_DEST_WIDTH-1:0] dest;
    logic [`DMA_USER_WIDTH-1:0] user;
    logic [7:0]                 b;
    base   = next_base + lane;
    dest   = $random(seed);
    user   = $random(seed);
    nbeats = (nbytes + 7) / 8;
    // Next packet starts on a fresh word with a gap behind this one
    next_base = next_base + 8 * ((lane + nbytes + 7) / 8) + 8;
    pb_q.push_back(base);
    pl_q.push_back(nbytes);
    da_q.push_back(base);
    dl_q.push_back(nbytes);
    dd_q.push_back(dest);
    du_q.push_back(user);
    for (int j = 0; j < nbeats; j++) begin
      if (j > 0 && ($random(seed) & 3) == 0) begin
        s_axis_tvalid = 1'b0;
        @(posedge clk);
        #1;
      end
      s_axis_tdata = '0;
      s_axis_tkeep = '0;
      // Full beats, then a tail that keeps only its low bytes
      for (int i = 0; i < `DMA_STRB_WIDTH; i++) begin
        if (8 * j + i < nbytes) begin
          b = $random(seed);
          s_axis_tdata[8*i +: 8] = b;
          s_axis_tkeep[i]        = 1'b1;
          eb_q.push_back(b);
        end
      end
      // Later beats carry other metadata, which must be ignored
      s_axis_tdest  = (j == 0) ? dest : $random(seed);
      s_axis_tuser  = (j == 0) ? user : $random(seed);
      wr_base_addr  = (j == 0) ? base : $random(seed);
      s_axis_tlast  = (j == nbeats - 1);
      s_axis_tvalid = 1'b1;
      wait_accept();
    end
    s_axis_tvalid = 1'b0;
  endtask

  task automatic run_packets(input int count);
    int         nbytes;
    logic [2:0] lane;
    for (int p = 0; p < count; p++) begin
      nbytes = 1 + ($random(seed) & 31);
      lane   = $random(seed);
      send_packet(nbytes, lane);
      if (($random(seed) & 1) == 0) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (pb_q.size() != 0 || da_q.size() != 0) begin
      t++;
      if (t > 3000) abort_run("the outstanding writes and descriptors");
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    #1;
  endtask

  task automatic report_test(input string name);
    int n;
    n = errors - errs_at_start;
    tests_run++;
    if (n != 0) tests_bad++;
    $display("test %0d %s: %0d errors", tests_run, name, n);
    errs_at_start = errors;
  endtask

  initial begin
    clk             = 1'b0;
    rst             = 1'b1;
    s_axis_tdata    = '0;
    s_axis_tkeep    = '0;
    s_axis_tvalid   = 1'b0;
    s_axis_tlast    = 1'b0;
    s_axis_tdest    = '0;
    s_axis_tuser    = '0;
    wr_base_addr    = '0;
    mem_wr_ready    = 1'b0;
    recv_desc_ready = 1'b0;
    seed            = 57;
    errors          = 0;
    errs_at_start   = 0;
    tests_run       = 0;
    tests_bad       = 0;
    started         = 1'b0;
    mem_rand        = 1'b0;
    desc_mode       = 0;
    next_base       = 16'h0100;
    wr_cnt          = 0;
    wr_bytes        = 0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (6) @(posedge clk);
    #1;
    report_test("reset state");

    started = 1'b1;
    run_packets(16);
    wait_drain();
    report_test("realignment and descriptors");

    mem_rand = 1'b1;
    run_packets(16);
    wait_drain();
    report_test("memory back-pressure");

    // Descriptor port held off first, then taken at random
    mem_rand  = 1'b0;
    desc_mode = 1;
    fork
      run_packets(12);
      begin
        repeat (60) @(posedge clk);
        desc_mode = 2;
      end
    join
    wait_drain();
    report_test("descriptor back-pressure");

    $display("tests run %0d, tests with errors %0d, errors %0d", tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+common
common/dma_pkg.sv
rx_path/rx_ingress_ctrl.sv
rx_path/rx_align_pipe.sv
rx_path/recv_desc_gen.sv
hw/axis_dma_rx.sv
tb/tb_axis_dma_rx.sv
